// ==== design/led_panel_pkg.sv ====
// LED panel shared definitions
`default_nettype none

package led_panel_pkg;

    // LED positions on the panel, one red and one green each
    localparam int led_pairs = 8;

    // serial word carries both colours
    localparam int sreg_bits = 2 * led_pairs;

    // word addresses of the register slave
    localparam logic [1:0] reg_red    = 2'd0;
    localparam logic [1:0] reg_green  = 2'd1;
    localparam logic [1:0] reg_aux    = 2'd2;
    localparam logic [1:0] reg_frames = 2'd3;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // register contents seen by the LED hardware
    typedef struct packed {
        logic [led_pairs-1:0] red;
        logic [led_pairs-1:0] green;
        logic [1:0]           bmc;
        logic [1:0]           exp;
    } led_state_t;

    // pins of the external shift register
    typedef struct packed {
        logic d;
        logic ld;
        logic clk;
    } sreg_pins_t;

endpackage

`default_nettype wire

// ==== design/led_wb_regs.sv ====
// LED register slave
`default_nettype none

module led_wb_regs (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire led_panel_pkg::wb_req_t   wb_req,
    output led_panel_pkg::wb_rsp_t        wb_rsp,
    input  wire logic                     frame_done,
    output led_panel_pkg::led_state_t     leds
);

    import led_panel_pkg::*;

    logic [led_pairs-1:0] red_q;
    logic [led_pairs-1:0] green_q;
    logic [1:0]           bmc_q;
    logic [1:0]           exp_q;
    logic [15:0]          frame_cnt;
    logic                 ack_q;
    logic                 req_new;
    logic [31:0]          rd_dat;
    logic [31:0]          rd_dat_q;

    // request present and not answered yet
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

    // read mux, unused upper bits read as zero
    always_comb begin
        rd_dat = '0;
        case (wb_req.adr)
            reg_red: begin
                rd_dat[led_pairs-1:0] = red_q;
            end
            reg_green: begin
                rd_dat[led_pairs-1:0] = green_q;
            end
            reg_aux: begin
                rd_dat[3:0] = {exp_q, bmc_q};
            end
            default: begin
                rd_dat[15:0] = frame_cnt;
            end
        endcase
    end

    // single-cycle ack, writes land on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            red_q   <= '0;
            green_q <= '0;
            bmc_q   <= '0;
            exp_q   <= '0;
        end else begin
            ack_q <= req_new;
            if (req_new && wb_req.we) begin
                case (wb_req.adr)
                    reg_red: begin
                        red_q <= wb_req.dat[led_pairs-1:0];
                    end
                    reg_green: begin
                        green_q <= wb_req.dat[led_pairs-1:0];
                    end
                    reg_aux: begin
                        bmc_q <= wb_req.dat[1:0];
                        exp_q <= wb_req.dat[3:2];
                    end
                    default: begin
                        // frame counter is read-only
                    end
                endcase
            end
        end
    end

    // completed frames, wraps at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 16'd1;
        end
    end

    // read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (req_new) begin
            rd_dat_q <= rd_dat;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

    assign leds = '{red: red_q, green: green_q, bmc: bmc_q, exp: exp_q};

endmodule

`default_nettype wire

// ==== design/led_prescale_timer.sv ====
// Shift clock prescale timer
`default_nettype none

module led_prescale_timer #(
    parameter int PRESCALE = 63
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic enable,
    output logic      tick
);

    // at least one bit so a zero prescale still builds
    localparam int cnt_w = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

    logic [cnt_w-1:0] cnt;

    assign tick = enable && (cnt == '0);

    // held at full count while disabled so each frame starts with a full period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= cnt_w'(PRESCALE);
        end else if (!enable || cnt == '0) begin
            cnt <= cnt_w'(PRESCALE);
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/led_sreg_fsm.sv ====
// LED shift register frame sequencer
`default_nettype none

module led_sreg_fsm (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic tick,
    input  wire logic changed,
    input  wire logic last_bit,
    output logic      capture,
    output logic      advance,
    output logic      timer_enable,
    output logic      frame_done,
    output logic      sreg_clk,
    output logic      sreg_ld
);

    typedef enum logic [1:0] {
        idle,
        bit_low,
        bit_high,
        load
    } state_t;

    state_t state;
    state_t state_next;
    logic   clk_q;
    logic   ld_q;

    // timer only runs inside a frame
    assign timer_enable = (state != idle);

    // snapshot taken on the way out of idle
    assign capture = (state == idle) && changed;

    // step to the next bit at the end of a high phase
    assign advance = (state == bit_high) && tick && !last_bit;

    // ld drops on the same edge
    assign frame_done = (state == load) && tick;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (changed) begin
                    state_next = bit_low;
                end
            end
            bit_low: begin
                if (tick) begin
                    state_next = bit_high;
                end
            end
            bit_high: begin
                if (tick) begin
                    state_next = last_bit ? load : bit_low;
                end
            end
            default: begin
                if (tick) begin
                    state_next = idle;
                end
            end
        endcase
    end

    // pin levels follow the next state, so they change with the state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            clk_q <= 1'b0;
            ld_q  <= 1'b0;
        end else begin
            state <= state_next;
            clk_q <= (state_next == bit_high);
            ld_q  <= (state_next == load);
        end
    end

    assign sreg_clk = clk_q;
    assign sreg_ld  = ld_q;

endmodule

`default_nettype wire

// ==== design/led_sreg_shifter.sv ====
// LED serial word shifter
`default_nettype none

module led_sreg_shifter #(
    parameter bit INVERT = 1'b1
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire led_panel_pkg::led_state_t  leds,
    input  wire logic                       capture,
    input  wire logic                       advance,
    input  wire logic                       sreg_clk_raw,
    input  wire logic                       sreg_ld_raw,
    output logic                            changed,
    output logic                            last_bit,
    output led_panel_pkg::sreg_pins_t       pins
);

    import led_panel_pkg::*;

    localparam int ptr_w = $clog2(sreg_bits);

    logic [sreg_bits-1:0] word;
    logic [sreg_bits-1:0] snap;
    logic                 snap_valid;
    logic [ptr_w-1:0]     ptr;
    logic                 d_raw;

    // even bits red, odd bits green
    always_comb begin
        for (int i = 0; i < led_pairs; i++) begin
            word[2*i]   = leds.red[i];
            word[2*i+1] = leds.green[i];
        end
    end

    // nothing shipped yet counts as a change
    assign changed  = !snap_valid || (word != snap);
    assign last_bit = (ptr == '0);

    // snapshot of the word in flight, msb first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snap       <= '0;
            snap_valid <= 1'b0;
            ptr        <= '0;
        end else if (capture) begin
            snap       <= word;
            snap_valid <= 1'b1;
            ptr        <= ptr_w'(sreg_bits - 1);
        end else if (advance) begin
            ptr <= ptr - 1'b1;
        end
    end

    assign d_raw = snap[ptr];

    // polarity of all three pins set here
    assign pins = '{
        d:   d_raw ^ INVERT,
        ld:  sreg_ld_raw ^ INVERT,
        clk: sreg_clk_raw ^ INVERT
    };

endmodule

`default_nettype wire

// ==== design/led_panel.sv ====
// Board status LED panel
`default_nettype none

module led_panel #(
    parameter int PRESCALE = 63,
    parameter bit INVERT   = 1'b1
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire led_panel_pkg::wb_req_t   wb_req,
    output led_panel_pkg::wb_rsp_t        wb_rsp,
    output led_panel_pkg::sreg_pins_t     sreg,
    output logic [1:0]                    led_bmc,
    output logic [1:0]                    led_exp
);

    import led_panel_pkg::*;

    led_state_t leds;
    logic       frame_done;
    logic       tick;
    logic       timer_enable;
    logic       changed;
    logic       last_bit;
    logic       capture;
    logic       advance;
    logic       sreg_clk_raw;
    logic       sreg_ld_raw;

    led_wb_regs led_wb_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .frame_done (frame_done),
        .leds       (leds)
    );

    // direct LED groups bypass the shift register
    assign led_bmc = leds.bmc;
    assign led_exp = leds.exp;

    led_prescale_timer #(
        .PRESCALE (PRESCALE)
    ) led_prescale_timer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (timer_enable),
        .tick   (tick)
    );

    led_sreg_fsm led_sreg_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .tick         (tick),
        .changed      (changed),
        .last_bit     (last_bit),
        .capture      (capture),
        .advance      (advance),
        .timer_enable (timer_enable),
        .frame_done   (frame_done),
        .sreg_clk     (sreg_clk_raw),
        .sreg_ld      (sreg_ld_raw)
    );

    led_sreg_shifter #(
        .INVERT (INVERT)
    ) led_sreg_shifter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .leds         (leds),
        .capture      (capture),
        .advance      (advance),
        .sreg_clk_raw (sreg_clk_raw),
        .sreg_ld_raw  (sreg_ld_raw),
        .changed      (changed),
        .last_bit     (last_bit),
        .pins         (sreg)
    );

endmodule

`default_nettype wire

// ==== sim/led_panel_tb.sv ====
// LED panel testbench
`default_nettype none

module led_panel_tb;

    import led_panel_pkg::*;

    localparam int          prescale      = 3;
    localparam bit          invert        = 1'b1;
    localparam int unsigned ack_timeout   = 20;
    localparam int unsigned frame_timeout = 2000;
    // longer than any pin-quiet stretch inside or between frames
    localparam int unsigned quiet_cycles  = 4 * (prescale + 1);

    logic        clk = 1'b0;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    sreg_pins_t  sreg;
    logic [1:0]  led_bmc;
    logic [1:0]  led_exp;

    // reference model state
    led_state_t           shadow;
    logic                 raw_d;
    logic                 raw_clk;
    logic                 raw_ld;
    logic                 clk_prev;
    logic                 ld_prev;
    logic [sreg_bits-1:0] shift_word;
    logic [sreg_bits-1:0] last_word;
    logic [31:0]          ld_count;

    int unsigned value_errors   = 0;
    int unsigned timeout_errors = 0;

    led_panel #(
        .PRESCALE (prescale),
        .INVERT   (invert)
    ) led_panel_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .sreg    (sreg),
        .led_bmc (led_bmc),
        .led_exp (led_exp)
    );

    always #2 clk = ~clk;

    // pin-level view of the external shift register
    assign raw_d   = sreg.d ^ invert;
    assign raw_clk = sreg.clk ^ invert;
    assign raw_ld  = sreg.ld ^ invert;

    always @(posedge clk) begin
        if (!rst_n) begin
            clk_prev   <= 1'b0;
            ld_prev    <= 1'b0;
            shift_word <= '0;
            last_word  <= '0;
            ld_count   <= '0;
        end else begin
            clk_prev <= raw_clk;
            ld_prev  <= raw_ld;
            // msb arrives first
            if (raw_clk && !clk_prev) begin
                shift_word <= {shift_word[sreg_bits-2:0], raw_d};
            end
            if (raw_ld && !ld_prev) begin
                last_word <= shift_word;
                ld_count  <= ld_count + 32'd1;
            end
        end
    end

    function automatic logic [31:0] model_read(input logic [1:0] adr);
        logic [31:0] val;
        val = '0;
        case (adr)
            reg_red:   val[led_pairs-1:0] = shadow.red;
            reg_green: val[led_pairs-1:0] = shadow.green;
            reg_aux:   val[3:0] = {shadow.exp, shadow.bmc};
            default:   val[15:0] = ld_count[15:0];
        endcase
        return val;
    endfunction

    task automatic check_wb_dat(input wb_rsp_t rsp, input logic [31:0] want);
        if (rsp.dat !== want) begin
            $display("ERR wb_rsp.dat got %h expected %h", rsp.dat, want);
            value_errors++;
        end
    endtask

    task automatic check_frame(input logic [sreg_bits-1:0] got, input led_state_t state);
        logic [sreg_bits-1:0] want;
        // green on odd positions and red on even ones
        for (int k = 0; k < sreg_bits; k++) begin
            want[k] = (k % 2 == 1) ? state.green[k / 2] : state.red[k / 2];
        end
        if (got !== want) begin
            $display("ERR sreg frame got %h expected %h", got, want);
            value_errors++;
        end
    endtask

    task automatic check_aux(input logic [1:0] got_bmc, input logic [1:0] got_exp,
                             input led_state_t state);
        if (got_bmc !== state.bmc) begin
            $display("ERR led_bmc got %h expected %h", got_bmc, state.bmc);
            value_errors++;
        end
        if (got_exp !== state.exp) begin
            $display("ERR led_exp got %h expected %h", got_exp, state.exp);
            value_errors++;
        end
    endtask

    task automatic check_pins(input sreg_pins_t got, input sreg_pins_t want);
        if (got !== want) begin
            $display("ERR sreg got %h expected %h", got, want);
            value_errors++;
        end
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             output wb_rsp_t rsp);
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ack_timeout);
        rsp = wb_rsp;
        if (!wb_rsp.ack) begin
            $display("timeout: register slave never acknowledged address %0d", adr);
            timeout_errors++;
        end
        wb_req <= '0;
        // shadow follows a write once it is acknowledged
        if (we && rsp.ack) begin
            case (adr)
                reg_red:   shadow.red = dat[led_pairs-1:0];
                reg_green: shadow.green = dat[led_pairs-1:0];
                reg_aux:   shadow = '{red: shadow.red, green: shadow.green,
                                      bmc: dat[1:0], exp: dat[3:2]};
                default:   ;
            endcase
        end
    endtask

    task automatic wait_frames(input int unsigned target);
        int unsigned waited;
        waited = 0;
        while (ld_count < target && waited < frame_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (ld_count < target) begin
            $display("timeout: only %0d of %0d frames arrived", ld_count, target);
            timeout_errors++;
        end
    endtask

    task automatic wait_idle();
        int unsigned quiet;
        int unsigned waited;
        quiet  = 0;
        waited = 0;
        while (quiet < quiet_cycles && waited < frame_timeout) begin
            @(posedge clk);
            waited++;
            quiet = (raw_clk || raw_ld) ? 0 : quiet + 1;
        end
        if (quiet < quiet_cycles) begin
            $display("timeout: shift register pins never went idle");
            timeout_errors++;
        end
    endtask

    initial begin
        wb_rsp_t     rsp;
        logic [1:0]  adr;
        logic [31:0] dat;
        void'($urandom(32'h9f54_cb10));
        rst_n  = 1'b0;
        wb_req = '0;
        shadow = '0;
        repeat (10) @(posedge clk);
        check_pins(sreg, '{d: invert, ld: invert, clk: invert});
        rst_n <= 1'b1;

        // one all-zero frame after reset and then silence
        wait_frames(1);
        check_frame(last_word, shadow);
        wait_idle();
        repeat (300) @(posedge clk);
        if (ld_count != 32'd1) begin
            $display("ERR ld_count got %h expected %h", ld_count, 32'd1);
            value_errors++;
        end
        check_pins(sreg, '{d: invert, ld: invert, clk: invert});

        // frame counter ignores writes
        wb_access(1'b0, reg_frames, '0, rsp);
        check_wb_dat(rsp, model_read(reg_frames));
        wb_access(1'b1, reg_frames, $urandom, rsp);
        wb_access(1'b0, reg_frames, '0, rsp);
        check_wb_dat(rsp, model_read(reg_frames));

        // single writes each followed by a complete frame
        repeat (16) begin
            adr = 2'($urandom % 3);
            dat = $urandom;
            wb_access(1'b1, adr, dat, rsp);
            @(posedge clk);
            check_aux(led_bmc, led_exp, shadow);
            wb_access(1'b0, adr, '0, rsp);
            check_wb_dat(rsp, model_read(adr));
            wait_idle();
            check_frame(last_word, shadow);
            wb_access(1'b0, reg_frames, '0, rsp);
            check_wb_dat(rsp, model_read(reg_frames));
        end

        // burst of writes while a frame is on the pins
        repeat (4) begin
            repeat (6) begin
                wb_access(1'b1, 2'($urandom % 2), $urandom, rsp);
            end
            wait_idle();
            check_frame(last_word, shadow);
            wb_access(1'b0, reg_frames, '0, rsp);
            check_wb_dat(rsp, model_read(reg_frames));
        end

        $display("errors: %0d mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== led_panel.f ====
design/led_panel_pkg.sv
design/led_wb_regs.sv
design/led_prescale_timer.sv
design/led_sreg_fsm.sv
design/led_sreg_shifter.sv
design/led_panel.sv
sim/led_panel_tb.sv
